// ==== include/coreDefs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// accumulator and memory word width
`define DATA_W 8
// data memory size in bytes
`define MEM_DEPTH 256
`endif

// ==== hdl/corePkg.sv ====
`include "coreDefs.svh"

package corePkg;

	// ------------------------------------------------
	// instruction word fields
	// ------------------------------------------------
	// opcode in bits 15..10, info field below it
	localparam int INSTR_W = 16;
	localparam int OP_W = 6;
	// info field doubles as absolute jump target
	localparam int PC_W = 10;
	// relative branch offset in two's complement
	localparam int OFFS_W = 6;

	// datapath and memory sizes
	localparam int WORD_W = `DATA_W;
	localparam int MEM_SIZE = `MEM_DEPTH;
	localparam int ADDR_W = $clog2(`MEM_DEPTH);

	// ------------------------------------------------
	// opcodes and control codes
	// ------------------------------------------------
	// NOP must stay at zero
	typedef enum logic [OP_W-1:0] {
		NOP, LDA, LDB, LDCA, LDCB, STA, STB,
		ADDA, ADDB, ADDCA, ADDCB, SUBA, SUBB, SUBCA, SUBCB,
		ANDA, ANDB, ANDCA, ANDCB, ORA, ORB, ORCA, ORCB,
		ASLA, ASRA, JMP,
		BAEQ, BANE, BACS, BACC, BAMI, BAPL,
		BBEQ, BBNE, BBCS, BBCC, BBMI, BBPL
	} opcode_t;

	// write-back destination
	typedef enum logic [2:0] {
		NO_LOAD, LOAD_CONST_A, LOAD_CONST_B, LOAD_MEM_A, LOAD_MEM_B,
		LOAD_ALU_A, LOAD_ALU_B
	} accCtrl_t;

	// memory action of the instruction in EX
	typedef enum logic [1:0] {
		MEM_NONE, MEM_READ, MEM_WRITE_A, MEM_WRITE_B
	} memCtrl_t;

	// bit 0 picks acc A for operand 1, bit 1 picks acc B for operand 2
	typedef enum logic [1:0] {
		SEL_CONSTANTS = 2'b00,
		SEL_ACUM_A_CONST_B = 2'b01,
		SEL_CONST_A_ACUM_B = 2'b10,
		SEL_ACUM_AB = 2'b11
	} opSel_t;

endpackage

// ==== hdl/alu.sv ====
module alu import corePkg::*; (
	input  logic [WORD_W-1:0] aluOper1,
	input  logic [WORD_W-1:0] aluOper2,
	input  logic              aluCarryIn,
	input  opcode_t           aluOp,
	output logic [WORD_W-1:0] aluData,
	output logic              aluCarryOut,
	output logic              aluBranch
);

	logic [WORD_W:0] sum;
	logic [WORD_W:0] diff;
	// minuend and subtrahend
	logic [WORD_W-1:0] subM;
	logic [WORD_W-1:0] subS;

	// SUBCB has B on operand 2 and the constant on operand 1
	assign subM = (aluOp == SUBCB) ? aluOper2 : aluOper1;
	assign subS = (aluOp == SUBCB) ? aluOper1 : aluOper2;

	assign sum = {1'b0, aluOper1} + {1'b0, aluOper2};
	// top bit is the borrow
	assign diff = {1'b0, subM} - {1'b0, subS};

	// ------------------------------------------------
	// arithmetic and logic
	// ------------------------------------------------
	always_comb begin
		aluData = '0;
		// logic ops and loads keep the carry
		aluCarryOut = aluCarryIn;
		case (aluOp)
			ADDA, ADDB, ADDCA, ADDCB: {aluCarryOut, aluData} = sum;
			SUBA, SUBB, SUBCA, SUBCB: {aluCarryOut, aluData} = diff;
			ANDA, ANDB, ANDCA, ANDCB: aluData = aluOper1 & aluOper2;
			ORA, ORB, ORCA, ORCB: aluData = aluOper1 | aluOper2;
			// msb goes out to carry
			ASLA: {aluCarryOut, aluData} = {aluOper1, 1'b0};
			// logical shift, lsb to carry
			ASRA: {aluData, aluCarryOut} = {1'b0, aluOper1};
			default: aluData = '0;
		endcase
	end

	// ------------------------------------------------
	// branch conditions
	// ------------------------------------------------
	always_comb begin
		case (aluOp)
			JMP: aluBranch = 1'b1;
			// acc A tests
			BAEQ: aluBranch = (aluOper1 == '0);
			BANE: aluBranch = (aluOper1 != '0);
			BAMI: aluBranch = aluOper1[WORD_W-1];
			BAPL: aluBranch = !aluOper1[WORD_W-1];
			// acc B tests
			BBEQ: aluBranch = (aluOper2 == '0);
			BBNE: aluBranch = (aluOper2 != '0);
			BBMI: aluBranch = aluOper2[WORD_W-1];
			BBPL: aluBranch = !aluOper2[WORD_W-1];
			// carry tests look the same for both accs
			BACS, BBCS: aluBranch = aluCarryIn;
			BACC, BBCC: aluBranch = !aluCarryIn;
			default: aluBranch = 1'b0;
		endcase
	end

endmodule

// ==== hdl/idDecoder.sv ====
module idDecoder import corePkg::*; (
	input  logic               aluClk,
	input  logic               rst,
	input  logic [INSTR_W-1:0] instr,
	input  logic [PC_W-1:0]    instrPc,
	output opcode_t            aluOp,
	output opSel_t             outSelMux,
	output accCtrl_t           controlAcum,
	output memCtrl_t           memControl,
	output logic [WORD_W-1:0]  constant,
	output logic [PC_W-1:0]    branchDirId
);

	// raw opcode field
	logic [OP_W-1:0] rawOp;
	// set for any opcode inside the enum
	logic opValid;
	opcode_t opNext;
	opSel_t selNext;
	accCtrl_t acumNext;
	memCtrl_t memNext;
	// sign extended relative offset
	logic [PC_W-1:0] offsExt;
	logic [PC_W-1:0] targetNext;

	assign rawOp = instr[INSTR_W-1 -: OP_W];
	assign offsExt = {{(PC_W-OFFS_W){instr[OFFS_W-1]}}, instr[OFFS_W-1:0]};

	// JMP is absolute, all others relative to own pc
	assign targetNext = (rawOp == JMP) ? instr[PC_W-1:0] : instrPc + offsExt;

	// ------------------------------------------------
	// opcode decode
	// ------------------------------------------------
	always_comb begin
		opValid = 1'b1;
		selNext = SEL_CONSTANTS;
		acumNext = NO_LOAD;
		memNext = MEM_NONE;
		case (rawOp)
			NOP, JMP: begin
				selNext = SEL_CONSTANTS;
			end
			LDA: begin
				acumNext = LOAD_MEM_A;
				memNext = MEM_READ;
			end
			LDB: begin
				acumNext = LOAD_MEM_B;
				memNext = MEM_READ;
			end
			LDCA: acumNext = LOAD_CONST_A;
			LDCB: acumNext = LOAD_CONST_B;
			// store data comes from the forwarded acc
			STA: begin
				memNext = MEM_WRITE_A;
				selNext = SEL_ACUM_A_CONST_B;
			end
			STB: begin
				memNext = MEM_WRITE_B;
				selNext = SEL_CONST_A_ACUM_B;
			end
			// A <- A op B
			ADDA, SUBA, ANDA, ORA: begin
				acumNext = LOAD_ALU_A;
				selNext = SEL_ACUM_AB;
			end
			// B <- A op B
			ADDB, SUBB, ANDB, ORB: begin
				acumNext = LOAD_ALU_B;
				selNext = SEL_ACUM_AB;
			end
			// A <- A op const, shifts only use operand 1
			ADDCA, SUBCA, ANDCA, ORCA, ASLA, ASRA: begin
				acumNext = LOAD_ALU_A;
				selNext = SEL_ACUM_A_CONST_B;
			end
			// B <- B op const
			ADDCB, SUBCB, ANDCB, ORCB: begin
				acumNext = LOAD_ALU_B;
				selNext = SEL_CONST_A_ACUM_B;
			end
			// branches test A on operand 1
			BAEQ, BANE, BACS, BACC, BAMI, BAPL: selNext = SEL_ACUM_A_CONST_B;
			// and B on operand 2
			BBEQ, BBNE, BBCS, BBCC, BBMI, BBPL: selNext = SEL_CONST_A_ACUM_B;
			// unknown codes behave as NOP
			default: opValid = 1'b0;
		endcase
		opNext = opValid ? opcode_t'(rawOp) : NOP;
	end

	// ------------------------------------------------
	// ID/EX register
	// ------------------------------------------------
	always_ff @(posedge aluClk) begin
		if (rst) begin
			aluOp <= NOP;
			outSelMux <= SEL_CONSTANTS;
			controlAcum <= NO_LOAD;
			memControl <= MEM_NONE;
		end else begin
			aluOp <= opNext;
			outSelMux <= selNext;
			controlAcum <= acumNext;
			memControl <= memNext;
		end
	end

	// constant also serves as memory address
	always_ff @(posedge aluClk) begin
		constant <= instr[WORD_W-1:0];
		branchDirId <= targetNext;
	end

endmodule

// ==== hdl/exStage.sv ====
module exStage import corePkg::*; (
	input  logic              aluClk,
	input  logic              rst,
	input  opcode_t           aluOp,
	input  opSel_t            outSelMux,
	input  accCtrl_t          controlAcum,
	input  memCtrl_t          memControl,
	input  logic [WORD_W-1:0] constant,
	input  logic [PC_W-1:0]   branchDirId,
	input  logic [WORD_W-1:0] accA,
	input  logic [WORD_W-1:0] accB,
	input  logic              carry,
	input  logic [WORD_W-1:0] memRdData,
	output accCtrl_t          wbCtrl,
	output logic [WORD_W-1:0] wbData,
	output logic              wbCarry,
	output logic [ADDR_W-1:0] memAddr,
	output logic [WORD_W-1:0] memWrData,
	output logic              memWe,
	output logic              branchTaken,
	output logic [PC_W-1:0]   branchDir
);

	// constant or alu result of the previous instruction
	logic [WORD_W-1:0] resultReg;
	logic carryChg;
	logic prevCarryChg;
	logic hazardA;
	logic hazardB;
	logic [WORD_W-1:0] realA;
	logic [WORD_W-1:0] realB;
	logic realCarry;
	logic [WORD_W-1:0] aluOper1;
	logic [WORD_W-1:0] aluOper2;
	logic [WORD_W-1:0] aluData;
	logic aluCarryOut;
	logic aluBranch;

	// ------------------------------------------------
	// hazards and forwarding
	// ------------------------------------------------
	// pending write-back value, loads come straight from memory
	assign wbData = (wbCtrl == LOAD_MEM_A || wbCtrl == LOAD_MEM_B) ? memRdData : resultReg;

	assign hazardA = wbCtrl inside {LOAD_CONST_A, LOAD_MEM_A, LOAD_ALU_A};
	assign hazardB = wbCtrl inside {LOAD_CONST_B, LOAD_MEM_B, LOAD_ALU_B};
	assign carryChg = aluOp inside {ADDA, ADDB, ADDCA, ADDCB, SUBA, SUBB, SUBCA, SUBCB,
		ASLA, ASRA};

	assign realA = hazardA ? wbData : accA;
	assign realB = hazardB ? wbData : accB;
	assign realCarry = prevCarryChg ? wbCarry : carry;

	// operand muxes
	assign aluOper1 = outSelMux[0] ? realA : constant;
	assign aluOper2 = outSelMux[1] ? realB : constant;

	// memory side
	assign memAddr = constant[ADDR_W-1:0];
	assign memWrData = (memControl == MEM_WRITE_B) ? realB : realA;
	assign memWe = (memControl == MEM_WRITE_A) || (memControl == MEM_WRITE_B);

	alu aluEx (
		.aluOper1(aluOper1),
		.aluOper2(aluOper2),
		.aluCarryIn(realCarry),
		.aluOp(aluOp),
		.aluData(aluData),
		.aluCarryOut(aluCarryOut),
		.aluBranch(aluBranch)
	);

	// ------------------------------------------------
	// EX/WB register
	// ------------------------------------------------
	always_ff @(posedge aluClk) begin
		if (rst) begin
			wbCtrl <= NO_LOAD;
			prevCarryChg <= 1'b0;
			branchTaken <= 1'b0;
		end else begin
			wbCtrl <= controlAcum;
			prevCarryChg <= carryChg;
			branchTaken <= aluBranch;
		end
	end

	always_ff @(posedge aluClk) begin
		resultReg <= (controlAcum == LOAD_CONST_A || controlAcum == LOAD_CONST_B) ?
			constant : aluData;
		wbCarry <= aluCarryOut;
		branchDir <= branchDirId;
	end

endmodule

// ==== hdl/accumulators.sv ====
module accumulators import corePkg::*; (
	input  logic              aluClk,
	input  logic              rst,
	input  accCtrl_t          wbCtrl,
	input  logic [WORD_W-1:0] wbData,
	input  logic              wbCarry,
	output logic [WORD_W-1:0] accA,
	output logic [WORD_W-1:0] accB,
	output logic              carry
);

	// destination strobes
	logic loadA;
	logic loadB;
	logic carryWe;

	assign loadA = wbCtrl inside {LOAD_CONST_A, LOAD_MEM_A, LOAD_ALU_A};
	assign loadB = wbCtrl inside {LOAD_CONST_B, LOAD_MEM_B, LOAD_ALU_B};
	// alu results only
	// AND and OR hand back the unchanged carry
	assign carryWe = (wbCtrl == LOAD_ALU_A) || (wbCtrl == LOAD_ALU_B);

	// ------------------------------------------------
	// accumulator registers
	// ------------------------------------------------
	always_ff @(posedge aluClk) begin
		if (rst) begin
			accA <= '0;
			accB <= '0;
			carry <= 1'b0;
		end else begin
			if (loadA) begin
				accA <= wbData;
			end
			if (loadB) begin
				accB <= wbData;
			end
			if (carryWe) begin
				carry <= wbCarry;
			end
		end
	end

endmodule

// ==== hdl/dataMem.sv ====
module dataMem import corePkg::*; (
	input  logic              aluClk,
	input  logic [ADDR_W-1:0] memAddr,
	input  logic [WORD_W-1:0] memWrData,
	input  logic              memWe,
	output logic [WORD_W-1:0] memRdData
);

	// byte array
	logic [WORD_W-1:0] mem [MEM_SIZE];

	// ------------------------------------------------
	// write port
	// ------------------------------------------------
	always_ff @(posedge aluClk) begin
		if (memWe) begin
			mem[memAddr] <= memWrData;
		end
	end

	// ------------------------------------------------
	// read port
	// ------------------------------------------------
	// registered read every cycle
	// a load sees a store issued one instruction earlier
	always_ff @(posedge aluClk) begin
		memRdData <= mem[memAddr];
	end

endmodule

// ==== hdl/cpuCore.sv ====
module cpuCore import corePkg::*; (
	input  logic               aluClk,
	input  logic               rst,
	input  logic [INSTR_W-1:0] instr,
	input  logic [PC_W-1:0]    instrPc,
	output logic [WORD_W-1:0]  accA,
	output logic [WORD_W-1:0]  accB,
	output logic               carry,
	output logic               branchTaken,
	output logic [PC_W-1:0]    branchDir
);

	// ID/EX controls
	opcode_t aluOp;
	opSel_t outSelMux;
	accCtrl_t controlAcum;
	memCtrl_t memControl;
	logic [WORD_W-1:0] constant;
	logic [PC_W-1:0] branchDirId;

	// write-back path
	accCtrl_t wbCtrl;
	logic [WORD_W-1:0] wbData;
	logic wbCarry;

	// memory port
	logic [ADDR_W-1:0] memAddr;
	logic [WORD_W-1:0] memWrData;
	logic memWe;
	logic [WORD_W-1:0] memRdData;

	// ------------------------------------------------
	// pipeline stages
	// ------------------------------------------------
	idDecoder decoder (
		.aluClk(aluClk),
		.rst(rst),
		.instr(instr),
		.instrPc(instrPc),
		.aluOp(aluOp),
		.outSelMux(outSelMux),
		.controlAcum(controlAcum),
		.memControl(memControl),
		.constant(constant),
		.branchDirId(branchDirId)
	);

	exStage ex (
		.aluClk(aluClk),
		.rst(rst),
		.aluOp(aluOp),
		.outSelMux(outSelMux),
		.controlAcum(controlAcum),
		.memControl(memControl),
		.constant(constant),
		.branchDirId(branchDirId),
		.accA(accA),
		.accB(accB),
		.carry(carry),
		.memRdData(memRdData),
		.wbCtrl(wbCtrl),
		.wbData(wbData),
		.wbCarry(wbCarry),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWe(memWe),
		.branchTaken(branchTaken),
		.branchDir(branchDir)
	);

	// ------------------------------------------------
	// state
	// ------------------------------------------------
	accumulators acum (
		.aluClk(aluClk),
		.rst(rst),
		.wbCtrl(wbCtrl),
		.wbData(wbData),
		.wbCarry(wbCarry),
		.accA(accA),
		.accB(accB),
		.carry(carry)
	);

	dataMem dmem (
		.aluClk(aluClk),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWe(memWe),
		.memRdData(memRdData)
	);

endmodule

// ==== tb/cpuCore_properties.sv ====
module cpuCore_properties import corePkg::*; (
	input logic              aluClk,
	input logic              rst,
	input opcode_t           aluOp,
	input accCtrl_t          wbCtrl,
	input logic              memWe,
	input logic              branchTaken,
	input logic [WORD_W-1:0] accA,
	input logic [WORD_W-1:0] accB
);
	timeunit 1ns;
	timeprecision 1ps;

	// number of property failures so far
	int unsigned failCount = 0;
	// JMP and the twelve conditional branches
	logic branchOp;

	assign branchOp = aluOp inside {[JMP:BBPL]};

	// ------------------------------------------------
	// pipeline properties
	// ------------------------------------------------
	// taken flag only one cycle after a branch sat in EX
	branchAfterOp: assert property (@(posedge aluClk) disable iff (rst)
		$rose(branchTaken) |-> $past(branchOp))
		else begin
			failCount++;
			$error("branchTaken rose without a branch opcode in EX");
		end

	// accumulators hold without a write-back
	holdOnNoLoad: assert property (@(posedge aluClk) disable iff (rst)
		(wbCtrl == NO_LOAD) |=> ($stable(accA) && $stable(accB)))
		else begin
			failCount++;
			$error("accumulator changed under NO_LOAD");
		end

	// write enable only while a store sits in EX
	noWriteOnRead: assert property (@(posedge aluClk) disable iff (rst)
		memWe |-> (aluOp inside {STA, STB}))
		else begin
			failCount++;
			$error("memory write enable without a store in EX");
		end

endmodule

// ==== tb/cpuCore_tb.sv ====
`include "coreDefs.svh"

module cpuCore_tb import corePkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_TIMEOUT = 100;

	logic aluClk = 1'b0;
	logic rst;
	logic [INSTR_W-1:0] instr;
	logic [PC_W-1:0] instrPc;
	logic [`DATA_W-1:0] accA;
	logic [`DATA_W-1:0] accB;
	logic carry;
	logic branchTaken;
	logic [PC_W-1:0] branchDir;

	// reference model state
	logic [`DATA_W-1:0] mA;
	logic [`DATA_W-1:0] mB;
	logic mC;
	logic [`DATA_W-1:0] mMem [`MEM_DEPTH];
	logic [PC_W-1:0] curPc;
	// expected {isBranch, taken, target} and {carry, A, B} in flight
	logic [11:0] brQ [$];
	logic [16:0] accQ [$];
	integer seed = 32'h4dd9db61;
	// opcode pool for the random run
	opcode_t randOps [20] = '{LDCA, LDCB, ADDA, ADDB, ADDCA, ADDCB, SUBA, SUBB,
		SUBCA, SUBCB, ANDA, ANDB, ANDCA, ANDCB, ORA, ORB, ORCA, ORCB, ASLA, ASRA};

	cpuCore UUT (
		.aluClk(aluClk),
		.rst(rst),
		.instr(instr),
		.instrPc(instrPc),
		.accA(accA),
		.accB(accB),
		.carry(carry),
		.branchTaken(branchTaken),
		.branchDir(branchDir)
	);

	bind cpuCore cpuCore_properties props (.*);

	// 8 ns clock
	always #4 aluClk = ~aluClk;

	// reset held for 16 cycles
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge aluClk);
		rst <= 1'b0;
	end

	// ------------------------------------------------
	// checking and reference model
	// ------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	// {isBranch, taken, target} from the model state before the instruction
	function automatic logic [11:0] branchResult(input opcode_t op,
		input logic [PC_W-1:0] info, input logic [PC_W-1:0] pc);
		int t;
		logic taken;
		logic isBr;
		// relative target from a 6-bit two's complement offset
		t = int'(pc) + int'(info[5:0]);
		if (info[5]) begin
			t = t - 64;
		end
		isBr = 1'b1;
		case (op)
			JMP: begin
				taken = 1'b1;
				t = int'(info);
			end
			BAEQ: taken = (mA == 0);
			BANE: taken = (mA != 0);
			BAMI: taken = mA[7];
			BAPL: taken = !mA[7];
			BBEQ: taken = (mB == 0);
			BBNE: taken = (mB != 0);
			BBMI: taken = mB[7];
			BBPL: taken = !mB[7];
			BACS, BBCS: taken = mC;
			BACC, BBCC: taken = !mC;
			default: begin
				isBr = 1'b0;
				taken = 1'b0;
			end
		endcase
		// wraps modulo 1024
		return {isBr, taken, t[9:0]};
	endfunction

	task automatic execute(input opcode_t op, input logic [PC_W-1:0] info);
		logic [`DATA_W-1:0] k;
		logic [`DATA_W-1:0] x;
		logic [`DATA_W-1:0] y;
		logic [`DATA_W-1:0] r;
		logic constForm;
		logic toB;
		k = info[7:0];
		constForm = op inside {ADDCA, ADDCB, SUBCA, SUBCB, ANDCA, ANDCB, ORCA, ORCB};
		toB = op inside {LDB, LDCB, ADDB, ADDCB, SUBB, SUBCB, ANDB, ANDCB, ORB, ORCB};
		// B constant forms work on B and all others on A
		x = (constForm && toB) ? mB : mA;
		y = constForm ? k : mB;
		r = x;
		case (op)
			ADDA, ADDB, ADDCA, ADDCB: begin
				mC = (int'(x) + int'(y)) > 255;
				r = x + y;
			end
			// carry means borrow
			SUBA, SUBB, SUBCA, SUBCB: begin
				mC = (x < y);
				r = x - y;
			end
			ANDA, ANDB, ANDCA, ANDCB: r = x & y;
			ORA, ORB, ORCA, ORCB: r = x | y;
			ASLA: begin
				mC = x[7];
				r = x << 1;
			end
			ASRA: begin
				mC = x[0];
				r = x >> 1;
			end
			LDA, LDB: r = mMem[k];
			LDCA, LDCB: r = k;
			STA: mMem[k] = mA;
			STB: mMem[k] = mB;
			default: r = x;
		endcase
		if (op inside {[LDA:LDCB], [ADDA:ASRA]}) begin
			if (toB) begin
				mB = r;
			end else begin
				mA = r;
			end
		end
	endtask

	// one instruction per clock and the checks due this cycle
	task automatic issue(input opcode_t op, input logic [PC_W-1:0] info);
		logic [11:0] brDue;
		logic [16:0] accDue;
		brQ.push_back(branchResult(op, info, curPc));
		execute(op, info);
		accQ.push_back({mC, mA, mB});
		@(posedge aluClk);
		instr <= {op, info};
		instrPc <= curPc;
		curPc = curPc + 1'b1;
		@(negedge aluClk);
		// branch outputs two edges after the drive edge
		if (brQ.size() == 3) begin
			brDue = brQ.pop_front();
			checkValue("branchTaken", branchTaken, brDue[10]);
			if (brDue[11]) begin
				checkValue("branchDir", branchDir, brDue[9:0]);
			end
		end
		// accumulators one edge later
		if (accQ.size() == 4) begin
			accDue = accQ.pop_front();
			checkValue("carry", carry, accDue[16]);
			checkValue("accA", accA, accDue[15:8]);
			checkValue("accB", accB, accDue[7:0]);
		end
		// bound pipeline properties
		checkValue("failCount", UUT.props.failCount, 0);
	endtask

	// ------------------------------------------------
	// directed tests
	// ------------------------------------------------
	task automatic resetState();
		int cycles;
		cycles = 0;
		while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
			@(negedge aluClk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			$display("** Error at %0d ns: reset still active after %0d cycles", $time, cycles);
			$display("TEST FAILED");
			$fatal(1, "reset timeout");
		end
		@(negedge aluClk);
		checkValue("accA", accA, 0);
		checkValue("accB", accB, 0);
		checkValue("carry", carry, 0);
		checkValue("branchTaken", branchTaken, 0);
	endtask

	task automatic addSubForwarding();
		issue(LDCA, 10'h0C8);
		issue(LDCB, 10'h064);
		// 200 + 100 overflows
		issue(ADDA, 10'h000);
		issue(SUBB, 10'h000);
		issue(ADDCB, 10'h038);
		issue(SUBCA, 10'h02C);
		issue(ADDB, 10'h000);
		issue(LDCA, 10'h07F);
		issue(ADDCA, 10'h001);
		issue(SUBA, 10'h000);
		// 0 - 1 borrows
		issue(SUBCB, 10'h001);
		issue(ADDB, 10'h000);
	endtask

	task automatic logicAndShifts();
		issue(LDCA, 10'h0FF);
		// carry set first so logic ops can show they keep it
		issue(ADDCA, 10'h001);
		issue(LDCA, 10'h0F0);
		issue(LDCB, 10'h03C);
		issue(ANDA, 10'h000);
		issue(ORB, 10'h000);
		issue(ANDCB, 10'h00F);
		issue(ORCA, 10'h081);
		issue(ANDB, 10'h000);
		issue(ORA, 10'h000);
		issue(ORCB, 10'h055);
		issue(ANDCA, 10'h0C3);
		issue(ASLA, 10'h000);
		issue(ASLA, 10'h000);
		issue(ASRA, 10'h000);
		issue(LDCA, 10'h081);
		issue(ASRA, 10'h000);
		issue(ORA, 10'h000);
	endtask

	task automatic memoryRoundTrip();
		issue(LDCA, 10'h05A);
		issue(STA, 10'h010);
		issue(LDCB, 10'h0C3);
		issue(STB, 10'h011);
		issue(LDA, 10'h011);
		issue(LDB, 10'h010);
		// load then use
		issue(ADDA, 10'h000);
		issue(STA, 10'h012);
		issue(LDB, 10'h012);
		issue(ORB, 10'h000);
		issue(LDCA, 10'h021);
		// store then load at the same address
		issue(STA, 10'h0FF);
		issue(LDA, 10'h0FF);
		issue(SUBCA, 10'h001);
	endtask

	task automatic branchOutcomes();
		curPc = 10'h100;
		issue(LDCA, 10'h000);
		issue(LDCB, 10'h080);
		issue(JMP, 10'h2A5);
		issue(BAEQ, 10'h005);
		issue(BANE, 10'h03E);
		issue(BBMI, 10'h03F);
		issue(BBPL, 10'h010);
		issue(BAPL, 10'h020);
		issue(BAMI, 10'h001);
		issue(BBEQ, 10'h002);
		issue(BBNE, 10'h021);
		issue(LDCA, 10'h0F0);
		// carry test right after an add
		issue(ADDCA, 10'h020);
		issue(BACS, 10'h030);
		issue(BBCC, 10'h00C);
		issue(SUBCA, 10'h001);
		issue(BACC, 10'h038);
		issue(BBCS, 10'h004);
		// target wraps past the top
		curPc = 10'h3FE;
		issue(BAEQ, 10'h007);
		issue(BANE, 10'h009);
		// and below zero
		curPc = 10'h002;
		issue(BBNE, 10'h038);
		issue(ASRA, 10'h000);
		// upper info bits ignored by relative branches
		issue(BACS, 10'h3FF);
	endtask

	task automatic randomAluRun();
		int i;
		int pick;
		for (i = 0; i < 200; i++) begin
			pick = {$random(seed)} % 20;
			issue(randOps[pick], PC_W'($random(seed)));
		end
	endtask

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin
		instr = '0;
		instrPc = '0;
		curPc = '0;
		mA = '0;
		mB = '0;
		mC = 1'b0;
		resetState();
		addSubForwarding();
		logicAndShifts();
		memoryRoundTrip();
		branchOutcomes();
		randomAluRun();
		// drain the pipeline with NOPs
		repeat (4) issue(NOP, 10'h000);
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/corePkg.sv
hdl/alu.sv
hdl/idDecoder.sv
hdl/exStage.sv
hdl/accumulators.sv
hdl/dataMem.sv
hdl/cpuCore.sv
tb/cpuCore_properties.sv
tb/cpuCore_tb.sv
